// ==== dv/tb_accel_sched.sv ====
`default_nettype none
`include "sched_cfg.svh"

module tb_accel_sched;

    localparam int VEC          = `SCHED_VEC_LEN;
    localparam int CREDITS      = `SCHED_CREDITS;
    localparam int NUM_LAYERS   = `SCHED_NUM_LAYERS;
    localparam int RUN_LAYERS   = 5;        // wraps 3 to 0 once
    localparam int LOAD_LIMIT   = VEC * 40;
    localparam int LAYER_CYCLES = `SCHED_LAYER0_BATCHES * (LOAD_LIMIT + 60) + 400;
    localparam int LATENCY      = VEC + 2;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic weight_valid = 1'b0;
    logic ifmap_valid = 1'b0;
    logic bias_valid = 1'b0;
    logic ext_start = 1'b0;
    sched_pkg::weight_t weight_data = '0;
    sched_pkg::ifmap_t  ifmap_data = '0;
    sched_pkg::bias_t   bias_data = '0;

    wire logic                 weight_credit;
    wire logic                 ifmap_credit;
    wire logic                 bias_credit;
    wire sched_pkg::acc_t      result;
    wire logic                 result_valid;
    wire sched_pkg::batch_id_t batch_id;
    wire sched_pkg::layer_id_t layer_id;
    wire logic                 layer_transition;
    wire logic                 clear_output;
    wire logic                 all_batches_complete;
    wire logic                 data_load_ready;
    wire logic                 start;

    accel_sched_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .weight_valid(weight_valid), .weight_data(weight_data), .weight_credit(weight_credit),
        .ifmap_valid(ifmap_valid), .ifmap_data(ifmap_data), .ifmap_credit(ifmap_credit),
        .bias_valid(bias_valid), .bias_data(bias_data), .bias_credit(bias_credit),
        .ext_start(ext_start), .result(result), .result_valid(result_valid),
        .batch_id(batch_id), .layer_id(layer_id), .layer_transition(layer_transition),
        .clear_output(clear_output), .all_batches_complete(all_batches_complete),
        .data_load_ready(data_load_ready), .start(start)
    );

    always #50 clk = ~clk;

    logic [31:0] rng_state = 32'd4760;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int trans_count = 0;

    // model copies of the buffer contents
    int w_model [VEC];
    int i_model [VEC];
    int b_model;

    sched_pkg::weight_t w_q [$];
    sched_pkg::ifmap_t  i_q [$];
    sched_pkg::bias_t   b_q [$];
    int w_cred = CREDITS;
    int i_cred = CREDITS;
    int b_cred = CREDITS;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int batches_for(int layer);
        case (layer)
            0: return `SCHED_LAYER0_BATCHES;
            1: return `SCHED_LAYER1_BATCHES;
            2: return `SCHED_LAYER2_BATCHES;
            default: return `SCHED_LAYER3_BATCHES;
        endcase
    endfunction

    function automatic int expected_dot();
        int s;
        s = b_model;
        for (int k = 0; k < VEC; k++) begin
            s += i_model[k] * w_model[k];
        end
        return s;
    endfunction

    task automatic check_value(string name, int actual, int expected);
        checks++;
        assert (actual == expected) else begin
            $display("[FAIL] %0t %s: expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(string name, int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // ****************************************
    // credit-respecting senders
    // ****************************************
    always @(posedge clk) begin : weight_sender
        logic [31:0] r;
        r = next_rand();
        if (!rst_n) begin
            weight_valid <= 1'b0;
            w_cred = CREDITS;
        end else begin
            if (weight_credit) begin
                w_cred++;
            end
            if (w_q.size() > 0 && w_cred > 0 && r[13:12] != 2'b00) begin
                weight_valid <= 1'b1;
                weight_data  <= w_q.pop_front();
                w_cred--;
            end else begin
                weight_valid <= 1'b0;
            end
            assert (w_cred <= CREDITS) else note_error("weight credits above the grant");
        end
    end

    always @(posedge clk) begin : ifmap_sender
        logic [31:0] r;
        r = next_rand();
        if (!rst_n) begin
            ifmap_valid <= 1'b0;
            i_cred = CREDITS;
        end else begin
            if (ifmap_credit) begin
                i_cred++;
            end
            if (i_q.size() > 0 && i_cred > 0 && r[13:12] != 2'b00) begin
                ifmap_valid <= 1'b1;
                ifmap_data  <= i_q.pop_front();
                i_cred--;
            end else begin
                ifmap_valid <= 1'b0;
            end
            assert (i_cred <= CREDITS) else note_error("ifmap credits above the grant");
        end
    end

    always @(posedge clk) begin : bias_sender
        logic [31:0] r;
        r = next_rand();
        if (!rst_n) begin
            bias_valid <= 1'b0;
            b_cred = CREDITS;
        end else begin
            if (bias_credit) begin
                b_cred++;
            end
            if (b_q.size() > 0 && b_cred > 0 && r[13:12] != 2'b00) begin
                bias_valid <= 1'b1;
                bias_data  <= b_q.pop_front();
                b_cred--;
            end else begin
                bias_valid <= 1'b0;
            end
            assert (b_cred <= CREDITS) else note_error("bias credits above the grant");
        end
    end

    // ****************************************
    // layer transition and clear monitor
    // ****************************************
    always @(negedge clk) begin : transition_monitor
        int phase;
        int exp_layer;
        if (!rst_n) begin
            phase = 0;
            exp_layer = 0;
        end else if (layer_transition) begin
            exp_layer = (exp_layer + 1) % NUM_LAYERS;  // wraps to 0
            trans_count++;
            check_value("layer_id", int'(layer_id), exp_layer);
            check_value("clear_output", int'(clear_output), 0);
            phase = 1;
        end else begin
            case (phase)
                1, 2: begin
                    check_value("clear_output", int'(clear_output), 1);
                    phase++;
                end
                3: begin
                    check_value("clear_output", int'(clear_output), 0);
                    phase = 0;
                end
                default: begin
                    if (clear_output) check_value("clear_output", 1, 0);
                end
            endcase
        end
    end

    // ****************************************
    // stimulus and model helpers
    // ****************************************
    task automatic queue_weights();
        logic [31:0] r;
        sched_pkg::weight_t w;
        for (int k = 0; k < VEC; k++) begin
            r = next_rand();
            case (r[4:2])
                3'd0: w = -8'sd128;         // extremes now and then
                3'd1: w = 8'sd127;
                default: w = sched_pkg::weight_t'(r[23:16]);
            endcase
            w_model[k] = int'(w);
            w_q.push_back(w);
        end
    endtask

    task automatic queue_ifmap();
        logic [31:0] r;
        sched_pkg::ifmap_t a;
        for (int k = 0; k < VEC; k++) begin
            r = next_rand();
            case (r[4:2])
                3'd0: a = 8'd0;
                3'd1: a = 8'd255;
                default: a = r[23:16];
            endcase
            i_model[k] = int'(a);
            i_q.push_back(a);
        end
    endtask

    task automatic queue_bias();
        logic [31:0] r;
        int v;
        r = next_rand();
        v = int'(r % 32'd400001) - 200000;  // keeps the sum inside 20 bits
        b_model = v;
        b_q.push_back(sched_pkg::bias_t'(v));
    endtask

    task automatic wait_loads();
        int n;
        n = 0;
        while ((w_q.size() != 0 || i_q.size() != 0 || b_q.size() != 0) && n < LOAD_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (n < LOAD_LIMIT) else note_error("a load did not finish sending");
        repeat (2) @(negedge clk);          // credit pulse and its count
        check_value("weight credits", w_cred, CREDITS);
        check_value("ifmap credits", i_cred, CREDITS);
        check_value("bias credits", b_cred, CREDITS);
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!result_valid && n < 4 * VEC);
        assert (result_valid) else note_error("result_valid never came");
        if (result_valid) begin
            check_value("result_valid latency", n, LATENCY);
            check_value("result", int'(result), expected_dot());
        end
    endtask

    task automatic run_batch(int layer, int batch);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!start && n < LOAD_LIMIT);
        assert (start) else note_error("start never came after the load");
        if (start) begin
            check_value("batch_id", int'(batch_id), batch);
            check_value("layer_id", int'(layer_id), layer);
            check_value("all_batches_complete", int'(all_batches_complete), 0);
            wait_result();
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin : main_seq
        int err0;
        int layer;
        repeat (8) @(posedge clk);
        @(negedge clk);
        err0 = errors;
        check_value("start", int'(start), 0);
        check_value("result_valid", int'(result_valid), 0);
        check_value("layer_transition", int'(layer_transition), 0);
        check_value("clear_output", int'(clear_output), 0);
        check_value("all_batches_complete", int'(all_batches_complete), 0);
        check_value("data_load_ready", int'(data_load_ready), 0);
        check_value("weight_credit", int'(weight_credit), 0);
        check_value("ifmap_credit", int'(ifmap_credit), 0);
        check_value("bias_credit", int'(bias_credit), 0);
        @(posedge clk);
        rst_n <= 1'b1;
        finish_test("reset values", err0);

        queue_ifmap();
        queue_bias();
        queue_weights();
        wait_loads();
        for (int step = 0; step < RUN_LAYERS; step++) begin
            err0 = errors;
            layer = step % NUM_LAYERS;
            for (int b = 0; b < batches_for(layer); b++) begin
                if (b > 0) begin
                    queue_weights();        // weights alone within a layer
                    wait_loads();
                end
                run_batch(layer, b);
            end
            @(negedge clk);
            check_value("all_batches_complete", int'(all_batches_complete), 1);
            $display("layer step %0d (layer %0d, %0d batches): %s", step, layer,
                     batches_for(layer), (errors > err0) ? "failed" : "ok");
            tests_run++;
            if (errors > err0) tests_failed++;
            if (step == RUN_LAYERS - 1) break;

            if (step == 0) begin
                // engine runs directly from the buffers while the FSM waits
                err0 = errors;
                @(posedge clk);
                ext_start <= 1'b1;
                @(posedge clk);
                ext_start <= 1'b0;
                wait_result();
                finish_test("external start", err0);
            end

            err0 = errors;
            queue_weights();
            wait_loads();
            for (int k = 0; k < 20; k++) begin
                @(negedge clk);
                assert (!start) else note_error("weights alone started a batch at a layer boundary");
                check_value("layer_id", int'(layer_id), layer);
                check_value("data_load_ready", int'(data_load_ready), 1);
            end
            queue_ifmap();
            queue_bias();
            wait_loads();
            finish_test("layer boundary hold", err0);
        end

        repeat (4) @(negedge clk);
        err0 = errors;
        check_value("layer_transition count", trans_count, RUN_LAYERS - 1);
        check_value("weight_credit count", w_cred, CREDITS);
        check_value("ifmap_credit count", i_cred, CREDITS);
        check_value("bias_credit count", b_cred, CREDITS);
        finish_test("credits and transitions", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (20 * LAYER_CYCLES) @(posedge clk);
        $display("watchdog expired, the run took longer than 20 layers of cycles");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
hw/sched_pkg.sv
hw/buffer_loader.sv
hw/batch_scheduler.sv
hw/dot_engine.sv
hw/accel_sched_top.sv
dv/tb_accel_sched.sv

// ==== hw/accel_sched_top.sv ====
`default_nettype none
`include "sched_cfg.svh"

module accel_sched_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       weight_valid,
    input  wire sched_pkg::weight_t   weight_data,
    output logic                      weight_credit,
    input  wire                       ifmap_valid,
    input  wire sched_pkg::ifmap_t    ifmap_data,
    output logic                      ifmap_credit,
    input  wire                       bias_valid,
    input  wire sched_pkg::bias_t     bias_data,
    output logic                      bias_credit,
    input  wire                       ext_start,
    output sched_pkg::acc_t           result,
    output logic                      result_valid,
    output sched_pkg::batch_id_t      batch_id,
    output sched_pkg::layer_id_t      layer_id,
    output logic                      layer_transition,
    output logic                      clear_output,
    output logic                      all_batches_complete,
    output logic                      data_load_ready,
    output logic                      start
);

    logic                      weight_done;
    logic                      ifmap_done;
    logic                      bias_done;
    logic [`SCHED_ADDR_W-1:0]  weight_addr;
    logic [`SCHED_ADDR_W-1:0]  ifmap_addr;
    sched_pkg::weight_t        weight_rd_data;
    sched_pkg::ifmap_t         ifmap_rd_data;
    sched_pkg::bias_t          bias_rd_data;

    // ****************************************
    // load buffers
    // ****************************************
    buffer_loader #(.payload_t(sched_pkg::weight_t), .DEPTH(`SCHED_VEC_LEN)) i_weight_loader (
        .clk(clk), .rst_n(rst_n),
        .wr_valid(weight_valid), .wr_data(weight_data), .credit(weight_credit),
        .done(weight_done), .rd_addr(weight_addr), .rd_data(weight_rd_data)
    );

    buffer_loader #(.payload_t(sched_pkg::ifmap_t), .DEPTH(`SCHED_VEC_LEN)) i_ifmap_loader (
        .clk(clk), .rst_n(rst_n),
        .wr_valid(ifmap_valid), .wr_data(ifmap_data), .credit(ifmap_credit),
        .done(ifmap_done), .rd_addr(ifmap_addr), .rd_data(ifmap_rd_data)
    );

    buffer_loader #(.payload_t(sched_pkg::bias_t), .DEPTH(1)) i_bias_loader (
        .clk(clk), .rst_n(rst_n),
        .wr_valid(bias_valid), .wr_data(bias_data), .credit(bias_credit),
        .done(bias_done), .rd_addr('0), .rd_data(bias_rd_data)     // single word
    );

    // ****************************************
    // sequencing and compute
    // ****************************************
    batch_scheduler i_scheduler (
        .clk(clk), .rst_n(rst_n),
        .weight_done(weight_done), .ifmap_done(ifmap_done), .bias_done(bias_done),
        .ext_start(ext_start), .batch_complete(result_valid),
        .start(start), .batch_id(batch_id), .layer_id(layer_id),
        .all_batches_complete(all_batches_complete), .layer_transition(layer_transition),
        .clear_output(clear_output), .auto_start_active(),
        .data_load_ready(data_load_ready)
    );

    dot_engine i_engine (
        .clk(clk), .rst_n(rst_n), .start(start),
        .ifmap_addr(ifmap_addr), .weight_addr(weight_addr),
        .ifmap_data(ifmap_rd_data), .weight_data(weight_rd_data), .bias_data(bias_rd_data),
        .result(result), .result_valid(result_valid)
    );

endmodule

`default_nettype wire

// ==== hw/batch_scheduler.sv ====
`default_nettype none
`include "sched_cfg.svh"

module batch_scheduler (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      weight_done,
    input  wire                      ifmap_done,
    input  wire                      bias_done,
    input  wire                      ext_start,
    input  wire                      batch_complete,
    output logic                     start,
    output sched_pkg::batch_id_t     batch_id,
    output sched_pkg::layer_id_t     layer_id,
    output logic                     all_batches_complete,
    output logic                     layer_transition,
    output logic                     clear_output,
    output logic                     auto_start_active,
    output logic                     data_load_ready
);

    localparam sched_pkg::layer_id_t LAST_LAYER =
        sched_pkg::layer_id_t'(`SCHED_NUM_LAYERS - 1);

    sched_pkg::batch_state_t state;
    sched_pkg::batch_state_t state_next;
    sched_pkg::batch_id_t    last_batch;

    logic weight_done_q;
    logic ifmap_done_q;
    logic bias_done_q;
    logic weight_loaded;
    logic ifmap_loaded;
    logic bias_loaded;
    logic all_loaded;
    logic layer_changed;
    logic auto_start;
    logic [1:0] clear_cnt;

    assign all_loaded = weight_loaded & ifmap_loaded & bias_loaded;

    always_comb begin
        case (layer_id)
            2'd0: last_batch = sched_pkg::batch_id_t'(`SCHED_LAYER0_BATCHES - 1);
            2'd1: last_batch = sched_pkg::batch_id_t'(`SCHED_LAYER1_BATCHES - 1);
            2'd2: last_batch = sched_pkg::batch_id_t'(`SCHED_LAYER2_BATCHES - 1);
            2'd3: last_batch = sched_pkg::batch_id_t'(`SCHED_LAYER3_BATCHES - 1);
        endcase
    end

    // ****************************************
    // load tracking
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_done_q <= 1'b0;
            ifmap_done_q  <= 1'b0;
            bias_done_q   <= 1'b0;
            weight_loaded <= 1'b0;
            ifmap_loaded  <= 1'b0;
            bias_loaded   <= 1'b0;
        end else begin
            weight_done_q <= weight_done;
            ifmap_done_q  <= ifmap_done;
            bias_done_q   <= bias_done;
            if (state == sched_pkg::st_arm) begin
                weight_loaded <= 1'b0;      // consumed by this batch
                if (batch_id == '0) begin
                    ifmap_loaded <= 1'b0;   // layer taken, reload for next
                    bias_loaded  <= 1'b0;
                end
            end
            if (weight_done && !weight_done_q) begin
                weight_loaded <= 1'b1;
            end
            if (ifmap_done && !ifmap_done_q) begin
                ifmap_loaded <= 1'b1;
            end
            if (bias_done && !bias_done_q) begin
                bias_loaded <= 1'b1;
            end
        end
    end

    // ****************************************
    // batch FSM
    // ****************************************
    always_comb begin
        state_next = state;
        case (state)
            sched_pkg::st_idle: begin
                if (all_loaded) state_next = sched_pkg::st_arm;
            end
            sched_pkg::st_arm: begin
                state_next = sched_pkg::st_running;
            end
            sched_pkg::st_running: begin
                if (batch_complete) begin
                    if (batch_id < last_batch) state_next = sched_pkg::st_next;
                    else state_next = sched_pkg::st_all_done;
                end
            end
            sched_pkg::st_next: begin
                if (weight_loaded) state_next = sched_pkg::st_arm;
            end
            sched_pkg::st_all_done: begin
                if (all_loaded) state_next = sched_pkg::st_arm;
            end
            default: state_next = sched_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sched_pkg::st_idle;
            batch_id   <= '0;
            auto_start <= 1'b0;
        end else begin
            state      <= state_next;
            auto_start <= (state == sched_pkg::st_arm);
            if (state == sched_pkg::st_next && weight_loaded) begin
                batch_id <= batch_id + 1'b1;
            end else if ((state == sched_pkg::st_idle || state == sched_pkg::st_all_done)
                         && all_loaded) begin
                batch_id <= '0;
            end
        end
    end

    // ****************************************
    // layer stepping and output clear
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_id      <= '0;
            layer_changed <= 1'b0;
            clear_cnt     <= 2'd0;
        end else begin
            layer_changed <= 1'b0;
            if (state == sched_pkg::st_all_done && all_loaded) begin
                layer_id      <= (layer_id == LAST_LAYER) ? '0 : layer_id + 1'b1;
                layer_changed <= 1'b1;
            end
            if (layer_changed) begin
                clear_cnt <= 2'd2;
            end else if (clear_cnt != 2'd0) begin
                clear_cnt <= clear_cnt - 2'd1;
            end
        end
    end

    assign layer_transition     = layer_changed;
    assign clear_output         = (clear_cnt != 2'd0);
    assign start                = auto_start | ext_start;
    assign auto_start_active    = auto_start;
    assign all_batches_complete = (state == sched_pkg::st_all_done);
    assign data_load_ready      = weight_loaded;

    a_state_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {sched_pkg::st_idle, sched_pkg::st_arm, sched_pkg::st_running,
                      sched_pkg::st_next, sched_pkg::st_all_done}
    );

    a_start_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && !ext_start) |=> (!start || ext_start)
    );

    a_clear_two_cycles : assert property (
        @(posedge clk) disable iff (!rst_n)
        (clear_output && $past(clear_output)) |=> !clear_output
    );

endmodule

`default_nettype wire

// ==== hw/buffer_loader.sv ====
`default_nettype none
`include "sched_cfg.svh"

module buffer_loader #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            wr_valid,
    input  wire payload_t                  wr_data,
    output logic                           credit,
    output logic                           done,
    input  wire logic [`SCHED_ADDR_W-1:0]  rd_addr,
    output payload_t                       rd_data
);

    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int SPENT_W = $clog2(`SCHED_CREDITS + 2);

    payload_t mem [0:DEPTH-1];

    logic [CNT_W-1:0]   wr_cnt;
    logic [CNT_W-1:0]   wr_idx;
    logic               last_q;             // last word of a load stored
    logic [SPENT_W-1:0] spent;              // sender view of used credits

    // a full buffer restarts at word 0
    assign wr_idx = (wr_cnt == CNT_W'(DEPTH)) ? '0 : wr_cnt;

    // ****************************************
    // word storage
    // ****************************************
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_idx[IDX_W-1:0]] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr[IDX_W-1:0]];

    // ****************************************
    // count, credit return and done
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            credit <= 1'b0;
            last_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            credit <= wr_valid;             // one credit per stored word
            last_q <= wr_valid && (wr_idx == CNT_W'(DEPTH - 1));
            if (wr_valid) begin
                wr_cnt <= wr_idx + 1'b1;
            end
            if (last_q) begin
                done <= 1'b1;
            end else if (wr_valid) begin
                done <= 1'b0;               // next load has begun
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spent <= '0;
        end else begin
            spent <= spent + SPENT_W'(wr_valid) - SPENT_W'(credit);
        end
    end

    // sender must hold a credit for every word it drives
    a_credit_respected : assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid |-> (spent < SPENT_W'(`SCHED_CREDITS))
    );

endmodule

`default_nettype wire

// ==== hw/dot_engine.sv ====
`default_nettype none
`include "sched_cfg.svh"

module dot_engine (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            start,
    output logic [`SCHED_ADDR_W-1:0]       ifmap_addr,
    output logic [`SCHED_ADDR_W-1:0]       weight_addr,
    input  wire sched_pkg::ifmap_t         ifmap_data,
    input  wire sched_pkg::weight_t        weight_data,
    input  wire sched_pkg::bias_t          bias_data,
    output sched_pkg::acc_t                result,
    output logic                           result_valid
);

    localparam logic [`SCHED_ADDR_W-1:0] LAST_IDX = `SCHED_ADDR_W'(`SCHED_VEC_LEN - 1);

    logic [`SCHED_ADDR_W-1:0] idx;
    logic                     run;          // accumulating
    logic                     fin;          // sum complete, publish next
    sched_pkg::acc_t          acc;
    sched_pkg::acc_t          prod;

    // unsigned activation times signed weight
    assign prod = sched_pkg::acc_t'({1'b0, ifmap_data}) * sched_pkg::acc_t'(weight_data);

    assign ifmap_addr  = idx;
    assign weight_addr = idx;

    // ****************************************
    // control
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx          <= '0;
            run          <= 1'b0;
            fin          <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            fin          <= run && (idx == LAST_IDX);
            result_valid <= fin;
            if (start) begin
                idx <= '0;
                run <= 1'b1;
            end else if (run) begin
                idx <= idx + 1'b1;
                if (idx == LAST_IDX) run <= 1'b0;
            end
        end
    end

    // ****************************************
    // datapath
    // ****************************************
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= bias_data;               // bias read at address 0
        end else if (run) begin
            acc <= acc + prod;
        end
        if (fin) begin
            result <= acc;
        end
    end

    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !(run || fin)
    );

endmodule

`default_nettype wire

// ==== hw/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

    // ****************************************
    // payload types
    // ****************************************
    typedef logic signed [7:0]  weight_t;   // signed weight
    typedef logic [7:0]         ifmap_t;    // unsigned activation
    typedef logic signed [19:0] bias_t;
    typedef logic signed [19:0] acc_t;      // 8 products + bias fit

    typedef logic [1:0] layer_id_t;
    typedef logic [2:0] batch_id_t;

    // ****************************************
    // scheduler phases
    // ****************************************
    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_arm      = 3'd1,                 // one cycle before start
        st_running  = 3'd2,
        st_next     = 3'd3,                 // waiting on weights only
        st_all_done = 3'd4                  // waiting on a full reload
    } batch_state_t;

endpackage

`default_nettype wire

// ==== include/sched_cfg.svh ====
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// ****************************************
// vector and flow control
// ****************************************
`define SCHED_VEC_LEN 8             // ifmap and weight words per batch
`define SCHED_ADDR_W 3              // vector index width
`define SCHED_CREDITS 4             // credits granted per loader after reset

// ****************************************
// layer sequencing
// ****************************************
`define SCHED_NUM_LAYERS 4
`define SCHED_LAYER0_BATCHES 8
`define SCHED_LAYER1_BATCHES 4
`define SCHED_LAYER2_BATCHES 1
`define SCHED_LAYER3_BATCHES 1

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the accelerator scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -f files.f \
        --top-module tb_accel_sched -o sim_tb_accel_sched \
    && ./obj_dir/sim_tb_accel_sched) || { echo "$out"; echo "build or run failed"; exit 1; }

echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && exit 0 || exit 1
